// ==== list.f ====
+incdir+hdl
hdl/fpu_pkg.sv
hdl/fp_classify.sv
hdl/fp_compare.sv
hdl/fp_int_convert.sv
hdl/fp_result_stage.sv
hdl/fp_unit_top.sv
verif/fp_unit_checker.sv
verif/fp_unit_tb.sv

// ==== Bender.yml ====
package:
  name: fp_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fpu_pkg.sv
      - hdl/fp_classify.sv
      - hdl/fp_compare.sv
      - hdl/fp_int_convert.sv
      - hdl/fp_result_stage.sv
      - hdl/fp_unit_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/fp_unit_checker.sv
      - verif/fp_unit_tb.sv

// ==== verif/fp_unit_tb.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_unit_tb;

    localparam int WAIT_LIMIT = 1000;             // Cycles per wait

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    logic [`FP_OP_W-1:0]    op;
    logic [`FP_W-1:0]       a;
    logic [`FP_W-1:0]       b;
    logic                   out_valid;
    logic                   out_ready;
    logic [`FP_W-1:0]       result;
    logic [`FP_FLAGS_W-1:0] fflags;

    integer seed;
    bit     ready_random;                         // Back-pressure on the output
    int     tests;

    fp_unit_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .fflags    (fflags)
    );

    fp_unit_checker chk0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .fflags    (fflags)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Stimulus generation

    function automatic logic [31:0] special_value();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:       return 32'h0000_0000;
            3'd1:       return 32'h8000_0000;
            3'd2:       return {r[31], 8'hFF, 23'd0};               // Infinity
            3'd3:       return {r[31], 8'hFF, 1'b1, r[24:3]};       // Quiet NaN
            3'd4:       return {r[31], 8'hFF, 1'b0, r[24:4], 1'b1}; // Signaling NaN
            3'd5, 3'd6: return {r[31], 8'h00, r[25:4], 1'b1};       // Subnormal
            default:    return {r[31], 8'd127, r[25:3]};            // Near one
        endcase
    endfunction

    // Kind 0 any pattern, 1 float near integer range, 2 integer of random size
    function automatic logic [31:0] operand(input int kind);
        logic [31:0] r;
        logic [31:0] s;
        logic [7:0]  ex;
        r = $random(seed);
        if (r[7:0] % 3 == 0)
            return special_value();
        case (kind)
            0: return r;
            1: begin
                ex = 8'd110 + {2'b0, r[30:25]};
                if (r[24:23] == 2'd0)
                    return {r[31], 8'd157 + {6'b0, r[22:21]}, 23'd0};  // 2^30 up to 2^33
                return {r[31], ex, r[22:0]};
            end
            default: begin
                s = $random(seed);
                return s >> r[4:0];
            end
        endcase
    endfunction

    function automatic logic [4:0] pick_op(input int group);
        logic [31:0] r;
        r = $random(seed);
        case (group)
            0: case (r % 5)
                0:       return `FP_OP_MIN;
                1:       return `FP_OP_MAX;
                2:       return `FP_OP_EQ;
                3:       return `FP_OP_LT;
                default: return `FP_OP_LE;
            endcase
            1: case (r % 4)
                0:       return `FP_OP_CVT_W;
                1:       return `FP_OP_CVT_WU;
                2:       return `FP_OP_CVT_S_W;
                default: return `FP_OP_CVT_S_WU;
            endcase
            2: case (r % 8)
                0:       return `FP_OP_SGNJ;
                1:       return `FP_OP_SGNJN;
                2:       return `FP_OP_SGNJX;
                3:       return `FP_OP_MV_X_W;
                4:       return `FP_OP_MV_W_X;
                5, 6:    return `FP_OP_CLASS;
                default: return r[8] ? {2'b11, r[6:4]} : 5'h07 + {3'b0, r[5:4]};  // Unknown
            endcase
            default: return r[4:0];                // Anything, dropped ops too
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Handshake tasks

    task automatic stop_on_timeout(input string what);
        $display("ERROR: DUT stopped answering while %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #2;
        r = $random(seed);
        if (ready_random)
            out_ready = r[0];
        else
            out_ready = 1'b1;
    endtask

    task automatic send_item(input logic [4:0] o, input logic [31:0] x, input logic [31:0] y);
        int cycles;
        bit taken;
        op       = o;
        a        = x;
        b        = y;
        in_valid = 1'b1;
        cycles   = 0;
        taken    = 1'b0;
        while (!taken && cycles < WAIT_LIMIT) begin
            #1;
            taken = in_ready;                     // Settled after out_ready moved
            next_cycle();
            cycles++;
        end
        in_valid = 1'b0;
        if (!taken)
            stop_on_timeout("waiting for in_ready");
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (chk0.pending != 0 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (chk0.pending != 0)
            stop_on_timeout("draining results");
    endtask

    task automatic run_items(input string name, input int group, input int count);
        int          err_base;
        int          item_base;
        int          i;
        logic [4:0]  o;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r;
        chk0.test_name = name;
        err_base  = chk0.errors;
        item_base = chk0.checked;
        for (i = 0; i < count; i++) begin
            o = pick_op(group);
            if (o == `FP_OP_CVT_S_W || o == `FP_OP_CVT_S_WU)
                x = operand(2);
            else if (o == `FP_OP_CVT_W || o == `FP_OP_CVT_WU)
                x = operand(1);
            else
                x = operand(0);
            r = $random(seed);
            if (r[2:0] == 3'd0)
                y = {r[31] ^ x[31], x[30:0]};     // Same magnitude, maybe other sign
            else
                y = operand(0);
            send_item(o, x, y);
        end
        drain();
        tests++;
        $display("%-16s %0d items checked, %0d errors", name,
                 chk0.checked - item_base, chk0.errors - err_base);
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        op           = '0;
        a            = '0;
        b            = '0;
        out_ready    = 1'b1;
        seed         = 8;
        ready_random = 1'b0;
        tests        = 0;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;

        // Checker looks at the idle outputs on the next edge
        chk0.test_name = "reset_state";
        next_cycle();
        tests++;
        $display("%-16s %0d errors", "reset_state", chk0.errors);

        run_items("compare_minmax", 0, 200);
        run_items("convert", 1, 200);
        run_items("sign_move_class", 2, 200);
        ready_random = 1'b1;
        run_items("back_pressure", 3, 300);

        $display("Tests: %0d, items checked: %0d, errors: %0d", tests, chk0.checked,
                 chk0.errors);
        if (chk0.errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verif/fp_unit_checker.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_unit_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic                    in_ready,
    input  logic [`FP_OP_W-1:0]     op,
    input  logic [`FP_W-1:0]        a,
    input  logic [`FP_W-1:0]        b,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  logic [`FP_W-1:0]        result,
    input  logic [`FP_FLAGS_W-1:0]  fflags
);

    // Entry is {op, a, b, flags, result}
    logic [105:0]           exp_q[$];
    logic [105:0]           entry;
    logic                   reset_last;
    logic                   accepted_last;
    logic                   held_last;
    logic [`FP_W-1:0]       held_result;
    logic [`FP_FLAGS_W-1:0] held_flags;
    int                     errors = 0;
    int                     checked = 0;
    int                     pending = 0;
    string                  test_name = "none";

    //////////////////////////////////////////////////
    // Reference model

    function automatic logic is_nan(input logic [31:0] w);
        return (w[30:23] == 8'hFF) && (w[22:0] != 23'd0);
    endfunction

    // Unsigned key that sorts like the float value, -0 below +0
    function automatic logic [31:0] key_of(input logic [31:0] w);
        return w[31] ? ~w : (w | 32'h8000_0000);
    endfunction

    function automatic logic [9:0] class_of(input logic [31:0] w);
        if (is_nan(w))
            return w[22] ? 10'h200 : 10'h100;
        if (w[30:23] == 8'hFF)
            return w[31] ? 10'h001 : 10'h080;
        if (w[30:0] == 31'd0)
            return w[31] ? 10'h008 : 10'h010;
        if (w[30:23] == 8'h00)
            return w[31] ? 10'h004 : 10'h020;
        return w[31] ? 10'h002 : 10'h040;
    endfunction

    function automatic logic [36:0] compare_model(input logic [4:0] o, input logic [31:0] x,
                                                  input logic [31:0] y);
        logic        nans;
        logic        snan_any;
        logic        zeros;
        logic        x_below;
        logic [31:0] res;
        logic        nv;
        nans     = is_nan(x) || is_nan(y);
        snan_any = (is_nan(x) && !x[22]) || (is_nan(y) && !y[22]);
        zeros    = (x[30:0] == 31'd0) && (y[30:0] == 31'd0);
        x_below  = key_of(x) < key_of(y);
        res      = 32'd0;
        nv       = 1'b0;
        case (o)
            `FP_OP_EQ: begin
                res[0] = !nans && (x == y || zeros);
                nv     = snan_any;
            end
            `FP_OP_LT: begin
                res[0] = !nans && x_below && !zeros;
                nv     = nans;
            end
            `FP_OP_LE: begin
                res[0] = !nans && (x_below || x == y || zeros);
                nv     = nans;
            end
            default: begin                              // MIN and MAX
                if (is_nan(x) && is_nan(y))
                    res = `FP_QNAN;
                else if (is_nan(x))
                    res = y;
                else if (is_nan(y))
                    res = x;
                else if (o == `FP_OP_MIN)
                    res = x_below ? x : y;
                else
                    res = x_below ? y : x;
                nv = snan_any;
            end
        endcase
        return {nv, 4'b0, res};
    endfunction

    // Truncates toward zero
    function automatic logic [36:0] float_to_int(input logic [31:0] w, input bit to_unsigned);
        int          e;
        logic [23:0] sig;
        logic [23:0] frac_mask;
        logic [63:0] mag;
        logic        lost;
        logic [31:0] res;
        e    = w[30:23];
        e    = e - 127;
        sig  = {1'b1, w[22:0]};
        mag  = 64'd0;
        lost = 1'b0;
        if (is_nan(w))
            return {5'b10000, to_unsigned ? 32'hFFFF_FFFF : 32'h7FFF_FFFF};
        if (e < 0) begin
            lost = w[30:0] != 31'd0;
        end else if (e > 40) begin
            mag = 64'hFFFF_FFFF_FFFF;                   // Far out of range, inf too
        end else if (e >= 23) begin
            mag = {40'd0, sig} << (e - 23);
        end else begin
            mag       = {40'd0, sig} >> (23 - e);
            frac_mask = (24'd1 << (23 - e)) - 24'd1;
            lost      = |(sig & frac_mask);
        end
        if (to_unsigned) begin
            if (w[31] && w[30:0] != 31'd0)
                return {5'b10000, 32'd0};
            if (mag > 64'hFFFF_FFFF)
                return {5'b10000, 32'hFFFF_FFFF};
            return {4'b0, lost, mag[31:0]};
        end
        if (w[31]) begin
            if (mag > 64'h8000_0000)
                return {5'b10000, 32'h8000_0000};
            res = -mag[31:0];
            return {4'b0, lost, res};
        end
        if (mag > 64'h7FFF_FFFF)
            return {5'b10000, 32'h7FFF_FFFF};
        return {4'b0, lost, mag[31:0]};
    endfunction

    // Round to nearest, ties to even
    function automatic logic [36:0] int_to_float(input logic [31:0] w, input bit from_signed);
        logic        sgn;
        logic [31:0] mag;
        logic [31:0] kept;
        logic [31:0] rem;
        logic [31:0] half;
        logic [7:0]  ex;
        int          p;
        int          sh;
        sgn = from_signed && w[31];
        mag = sgn ? (~w + 32'd1) : w;
        if (mag == 32'd0)
            return 37'd0;
        p = 31;
        while (!mag[p])
            p = p - 1;
        if (p <= 23) begin
            kept = mag << (23 - p);                     // Exact, no rounding
            rem  = 32'd0;
        end else begin
            sh   = p - 23;
            kept = mag >> sh;
            rem  = mag & ((32'd1 << sh) - 32'd1);
            half = 32'd1 << (sh - 1);
            if (rem > half || (rem == half && kept[0]))
                kept = kept + 32'd1;
            if (kept[24]) begin                         // Rounded up to next power of two
                kept = kept >> 1;
                p    = p + 1;
            end
        end
        ex = 8'(p + 127);
        return {4'b0, rem != 32'd0, sgn, ex, kept[22:0]};
    endfunction

    function automatic logic [36:0] model(input logic [4:0] o, input logic [31:0] x,
                                          input logic [31:0] y);
        case (o)
            `FP_OP_MIN, `FP_OP_MAX, `FP_OP_EQ, `FP_OP_LT, `FP_OP_LE:
                return compare_model(o, x, y);
            `FP_OP_CVT_W:    return float_to_int(x, 1'b0);
            `FP_OP_CVT_WU:   return float_to_int(x, 1'b1);
            `FP_OP_CVT_S_W:  return int_to_float(x, 1'b1);
            `FP_OP_CVT_S_WU: return int_to_float(x, 1'b0);
            `FP_OP_SGNJ:     return {5'b0, y[31], x[30:0]};
            `FP_OP_SGNJN:    return {5'b0, ~y[31], x[30:0]};
            `FP_OP_SGNJX:    return {5'b0, x[31] ^ y[31], x[30:0]};
            `FP_OP_MV_X_W, `FP_OP_MV_W_X:
                return {5'b0, x};
            `FP_OP_CLASS:    return {5'b0, 22'd0, class_of(x)};
            default:         return 37'd0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Scoreboard

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            reset_last    = 1'b1;
            accepted_last = 1'b0;
            held_last     = 1'b0;
        end else begin
            // Idle outputs on the first edge out of reset
            if (reset_last) begin
                if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
                    errors++;
                    $display("FAIL %s: valid/ready expected 0/1 actual %b/%b",
                             test_name, out_valid, in_ready);
                end
                if (result !== '0 || fflags !== '0) begin
                    errors++;
                    $display("FAIL %s: result expected 0/0 actual %h/%b",
                             test_name, result, fflags);
                end
            end
            if (accepted_last && !out_valid) begin
                errors++;
                $display("ERROR %s: output did not appear one cycle after its input", test_name);
            end
            if (held_last && (!out_valid || result !== held_result || fflags !== held_flags)) begin
                errors++;
                $display("ERROR %s: output changed while out_ready was low", test_name);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR %s: output appeared with no input outstanding", test_name);
                end else begin
                    entry = exp_q.pop_front();
                    checked++;
                    if (result !== entry[31:0] || fflags !== entry[36:32]) begin
                        errors++;
                        $display("FAIL %s: op %h a %h b %h expected %h/%b actual %h/%b",
                                 test_name, entry[105:101], entry[100:69], entry[68:37],
                                 entry[31:0], entry[36:32], result, fflags);
                    end
                end
            end
            if (in_valid && in_ready)
                exp_q.push_back({op, a, b, model(op, a, b)});
            reset_last    = 1'b0;
            accepted_last = in_valid && in_ready;
            held_last     = out_valid && !out_ready;
            held_result   = result;
            held_flags    = fflags;
        end
        pending = exp_q.size();
    end

endmodule

// ==== hdl/fp_unit_top.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_unit_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`FP_OP_W-1:0]     op,
    input  logic [`FP_W-1:0]        a,
    input  logic [`FP_W-1:0]        b,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [`FP_W-1:0]        result,
    output logic [`FP_FLAGS_W-1:0]  fflags
);

    // Operand status
    logic                   a_zero;
    logic                   a_inf;
    logic                   a_nan;
    logic                   a_snan;
    logic [`FP_CLASS_W-1:0] a_class;
    logic                   b_zero;
    logic                   b_nan;
    logic                   b_snan;

    // Datapath results
    logic [`FP_W-1:0]       cmp_result;
    logic [`FP_FLAGS_W-1:0] cmp_flags;
    logic [`FP_W-1:0]       cvt_result;
    logic [`FP_FLAGS_W-1:0] cvt_flags;

    fp_classify u_class_a (
        .word       (a),
        .is_zero    (a_zero),
        .is_inf     (a_inf),
        .is_nan     (a_nan),
        .is_snan    (a_snan),
        .class_mask (a_class)
    );

    // Only a is classified for CLASS, b needs no infinity check
    fp_classify u_class_b (
        .word       (b),
        .is_zero    (b_zero),
        .is_inf     (),
        .is_nan     (b_nan),
        .is_snan    (b_snan),
        .class_mask ()
    );

    fp_compare u_compare (
        .op         (op),
        .a          (a),
        .b          (b),
        .a_nan      (a_nan),
        .a_snan     (a_snan),
        .a_zero     (a_zero),
        .b_nan      (b_nan),
        .b_snan     (b_snan),
        .b_zero     (b_zero),
        .cmp_result (cmp_result),
        .cmp_flags  (cmp_flags)
    );

    fp_int_convert u_convert (
        .op         (op),
        .a          (a),
        .a_nan      (a_nan),
        .a_inf      (a_inf),
        .a_zero     (a_zero),
        .cvt_result (cvt_result),
        .cvt_flags  (cvt_flags)
    );

    fp_result_stage u_result (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .op           (op),
        .a            (a),
        .b            (b),
        .class_mask_a (a_class),
        .cmp_result   (cmp_result),
        .cmp_flags    (cmp_flags),
        .cvt_result   (cvt_result),
        .cvt_flags    (cvt_flags),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .result       (result),
        .fflags       (fflags)
    );

endmodule

// ==== hdl/fp_result_stage.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_result_stage import fpu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`FP_OP_W-1:0]     op,
    input  fp_word_u                a,
    input  fp_word_u                b,
    input  logic [`FP_CLASS_W-1:0]  class_mask_a,
    input  logic [`FP_W-1:0]        cmp_result,
    input  logic [`FP_FLAGS_W-1:0]  cmp_flags,
    input  logic [`FP_W-1:0]        cvt_result,
    input  logic [`FP_FLAGS_W-1:0]  cvt_flags,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [`FP_W-1:0]        result,
    output logic [`FP_FLAGS_W-1:0]  fflags
);

    logic [`FP_W-1:0]       sel_result;
    logic [`FP_FLAGS_W-1:0] sel_flags;
    logic                   accept;

    //////////////////////////////////////////////////
    // Opcode select

    always_comb begin
        sel_result = '0;
        sel_flags  = '0;
        case (op)
            `FP_OP_MIN, `FP_OP_MAX, `FP_OP_EQ, `FP_OP_LT, `FP_OP_LE: begin
                sel_result = cmp_result;
                sel_flags  = cmp_flags;
            end
            `FP_OP_CVT_W, `FP_OP_CVT_WU, `FP_OP_CVT_S_W, `FP_OP_CVT_S_WU: begin
                sel_result = cvt_result;
                sel_flags  = cvt_flags;
            end
            // Sign injection keeps the magnitude of a
            `FP_OP_SGNJ:   sel_result = {b.fields.sign, a.raw[`FP_W-2:0]};
            `FP_OP_SGNJN:  sel_result = {~b.fields.sign, a.raw[`FP_W-2:0]};
            `FP_OP_SGNJX:  sel_result = {a.fields.sign ^ b.fields.sign, a.raw[`FP_W-2:0]};
            `FP_OP_MV_X_W, `FP_OP_MV_W_X: begin
                sel_result = a.raw;                   // Bit pattern unchanged
            end
            `FP_OP_CLASS: begin
                sel_result = {{(`FP_W-`FP_CLASS_W){1'b0}}, class_mask_a};
            end
            default: ;                                // Unknown op gives zero
        endcase
    end

    //////////////////////////////////////////////////
    // Output register with valid/ready

    // Free slot, or the held item leaves this cycle
    assign in_ready = ~out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            result    <= '0;
            fflags    <= '0;
        end else if (accept) begin
            out_valid <= 1'b1;
            result    <= sel_result;
            fflags    <= sel_flags;
        end else if (out_ready) begin
            out_valid <= 1'b0;                        // Drained, nothing new
        end
    end

endmodule

// ==== hdl/fp_int_convert.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_int_convert import fpu_pkg::*; (
    input  logic [`FP_OP_W-1:0]     op,
    input  fp_word_u                a,
    input  logic                    a_nan,
    input  logic                    a_inf,
    input  logic                    a_zero,
    output logic [`FP_W-1:0]        cvt_result,
    output logic [`FP_FLAGS_W-1:0]  cvt_flags
);

    localparam logic [`FP_EXP_W-1:0] BIAS      = `FP_BIAS;
    localparam logic [`FP_EXP_W-1:0] EXP_S_MAX = `FP_BIAS + 31;  // Exponent of 2^31
    localparam logic [`FP_EXP_W-1:0] EXP_U_MAX = `FP_BIAS + 32;  // Exponent of 2^32

    //////////////////////////////////////////////////
    // Float to integer

    logic                 below_one;
    logic [`FP_EXP_W-1:0] shift_amt;
    logic [55:0]          shifted;     // Integer part in [54:23]
    logic [`FP_W-1:0]     int_part;
    logic                 frac_lost;
    logic                 min_int;

    assign below_one = a.fields.exponent < BIAS;
    assign shift_amt = a.fields.exponent - BIAS;

    // Only used while the exponent is in 0..31
    assign shifted   = {32'b0, 1'b1, a.fields.mantissa} << shift_amt[4:0];
    assign int_part  = shifted[54:23];
    assign frac_lost = |shifted[22:0];

    // -2^31 is the one value at that exponent that fits
    assign min_int = a.fields.sign & (a.fields.exponent == EXP_S_MAX) &
                     (a.fields.mantissa == '0);

    //////////////////////////////////////////////////
    // Integer to float, round to nearest even

    logic             i_sign;
    logic [`FP_W-1:0] i_mag;
    logic [4:0]       lzc;
    logic [`FP_W-1:0] i_norm;
    logic             guard;
    logic             sticky;
    logic             round_up;
    logic [`FP_W-2:0] i_rounded;   // Exponent and mantissa

    assign i_sign = (op == `FP_OP_CVT_S_W) & a.raw[`FP_W-1];
    assign i_mag  = i_sign ? -a.raw : a.raw;

    // Leading zero count; highest set bit wins
    always_comb begin
        lzc = 5'd0;
        for (int i = 0; i < `FP_W; i++) begin
            if (i_mag[i]) lzc = 5'(31 - i);
        end
    end

    assign i_norm   = i_mag << lzc;                 // Leading one at bit 31
    assign guard    = i_norm[7];
    assign sticky   = |i_norm[6:0];
    assign round_up = guard & (sticky | i_norm[8]);  // Ties go to even

    // Mantissa carry ripples into the exponent
    assign i_rounded = {EXP_S_MAX - {3'b0, lzc}, i_norm[30:8]} + {30'b0, round_up};

    //////////////////////////////////////////////////
    // Result and flags

    always_comb begin
        cvt_result = '0;
        cvt_flags  = '0;
        case (op)
            `FP_OP_CVT_W: begin
                if (a_nan) begin
                    cvt_result = 32'h7FFFFFFF;
                    cvt_flags[`FP_FLAG_NV] = 1'b1;
                end else if (min_int) begin
                    cvt_result = 32'h80000000;
                end else if (a_inf || a.fields.exponent >= EXP_S_MAX) begin
                    cvt_result = a.fields.sign ? 32'h80000000 : 32'h7FFFFFFF;
                    cvt_flags[`FP_FLAG_NV] = 1'b1;
                end else if (below_one) begin
                    cvt_flags[`FP_FLAG_NX] = ~a_zero;   // Truncates to 0
                end else begin
                    cvt_result = a.fields.sign ? -int_part : int_part;
                    cvt_flags[`FP_FLAG_NX] = frac_lost;
                end
            end
            `FP_OP_CVT_WU: begin
                if (a_nan) begin
                    cvt_result = 32'hFFFFFFFF;
                    cvt_flags[`FP_FLAG_NV] = 1'b1;
                end else if (a.fields.sign) begin
                    cvt_flags[`FP_FLAG_NV] = ~a_zero;   // -0 converts cleanly
                end else if (a_inf || a.fields.exponent >= EXP_U_MAX) begin
                    cvt_result = 32'hFFFFFFFF;
                    cvt_flags[`FP_FLAG_NV] = 1'b1;
                end else if (below_one) begin
                    cvt_flags[`FP_FLAG_NX] = ~a_zero;
                end else begin
                    cvt_result = int_part;
                    cvt_flags[`FP_FLAG_NX] = frac_lost;
                end
            end
            `FP_OP_CVT_S_W, `FP_OP_CVT_S_WU: begin
                if (i_mag != '0) begin
                    cvt_result = {i_sign, i_rounded};
                    cvt_flags[`FP_FLAG_NX] = guard | sticky;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/fp_compare.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_compare import fpu_pkg::*; (
    input  logic [`FP_OP_W-1:0]     op,
    input  fp_word_u                a,
    input  fp_word_u                b,
    input  logic                    a_nan,
    input  logic                    a_snan,
    input  logic                    a_zero,
    input  logic                    b_nan,
    input  logic                    b_snan,
    input  logic                    b_zero,
    output logic [`FP_W-1:0]        cmp_result,
    output logic [`FP_FLAGS_W-1:0]  cmp_flags
);

    logic             sign_a;
    logic             sign_b;
    logic [`FP_W-2:0] mag_a;
    logic [`FP_W-2:0] mag_b;
    logic             both_zero;
    logic             any_nan;
    logic             any_snan;
    logic             ord_lt;
    logic             eq;
    logic             lt;
    logic             le;

    assign sign_a = a.fields.sign;
    assign sign_b = b.fields.sign;
    assign mag_a  = a.raw[`FP_W-2:0];
    assign mag_b  = b.raw[`FP_W-2:0];

    assign both_zero = a_zero & b_zero;
    assign any_nan   = a_nan | b_nan;
    assign any_snan  = a_snan | b_snan;

    // Sign-magnitude order, -0 below +0
    assign ord_lt = (sign_a != sign_b) ? sign_a :
                    (sign_a ? (mag_a > mag_b) : (mag_a < mag_b));

    // Numeric relations treat the two zeros as equal
    assign eq = ~any_nan & ((a.raw == b.raw) | both_zero);
    assign lt = ~any_nan & ord_lt & ~both_zero;
    assign le = lt | eq;

    always_comb begin
        cmp_result = '0;
        cmp_flags  = '0;
        case (op)
            `FP_OP_EQ: begin
                cmp_result = {{(`FP_W-1){1'b0}}, eq};
                cmp_flags[`FP_FLAG_NV] = any_snan;  // Quiet compare
            end
            `FP_OP_LT: begin
                cmp_result = {{(`FP_W-1){1'b0}}, lt};
                cmp_flags[`FP_FLAG_NV] = any_nan;   // Signaling compare
            end
            `FP_OP_LE: begin
                cmp_result = {{(`FP_W-1){1'b0}}, le};
                cmp_flags[`FP_FLAG_NV] = any_nan;
            end
            `FP_OP_MIN, `FP_OP_MAX: begin
                if (a_nan & b_nan) begin
                    cmp_result = `FP_QNAN;
                end else if (a_nan) begin
                    cmp_result = b.raw;
                end else if (b_nan) begin
                    cmp_result = a.raw;
                end else if (op == `FP_OP_MIN) begin
                    cmp_result = ord_lt ? a.raw : b.raw;
                end else begin
                    cmp_result = ord_lt ? b.raw : a.raw;
                end
                cmp_flags[`FP_FLAG_NV] = any_snan;
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/fp_classify.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_classify import fpu_pkg::*; (
    input  fp_word_u                word,
    output logic                    is_zero,
    output logic                    is_inf,
    output logic                    is_nan,
    output logic                    is_snan,
    output logic [`FP_CLASS_W-1:0]  class_mask
);

    logic exp_ones;
    logic exp_zero;
    logic mant_zero;
    logic is_sub;
    logic is_norm;
    logic is_qnan;
    logic neg;

    assign exp_ones  = &word.fields.exponent;
    assign exp_zero  = ~|word.fields.exponent;
    assign mant_zero = ~|word.fields.mantissa;
    assign neg       = word.fields.sign;

    assign is_zero = exp_zero & mant_zero;
    assign is_sub  = exp_zero & ~mant_zero;
    assign is_norm = ~exp_zero & ~exp_ones;
    assign is_inf  = exp_ones & mant_zero;
    assign is_nan  = exp_ones & ~mant_zero;

    // Quiet bit is the mantissa MSB
    assign is_snan = is_nan & ~word.fields.mantissa[`FP_MANT_W-1];
    assign is_qnan = is_nan & word.fields.mantissa[`FP_MANT_W-1];

    // One-hot RISC-V class mask
    assign class_mask[0] = neg & is_inf;
    assign class_mask[1] = neg & is_norm;
    assign class_mask[2] = neg & is_sub;
    assign class_mask[3] = neg & is_zero;
    assign class_mask[4] = ~neg & is_zero;
    assign class_mask[5] = ~neg & is_sub;
    assign class_mask[6] = ~neg & is_norm;
    assign class_mask[7] = ~neg & is_inf;
    assign class_mask[8] = is_snan;           // Sign ignored for NaNs
    assign class_mask[9] = is_qnan;

endmodule

// ==== hdl/fpu_pkg.sv ====
`include "fpu_macros.svh"

package fpu_pkg;

    //////////////////////////////////////////////////
    // Single-precision fields

    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exponent;  // Biased
        logic [`FP_MANT_W-1:0] mantissa;  // Without hidden bit
    } fp_fields_t;

    //////////////////////////////////////////////////
    // Operand word, read as a float or as a raw integer

    // Raw view serves int-to-float and the moves
    typedef union packed {
        fp_fields_t       fields;
        logic [`FP_W-1:0] raw;
    } fp_word_u;

endpackage

// ==== hdl/fpu_macros.svh ====
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// Word layout
`define FP_W        32
`define FP_EXP_W    8
`define FP_MANT_W   23
`define FP_BIAS     127

`define FP_OP_W     5
`define FP_FLAGS_W  5             // {NV, DZ, OF, UF, NX}
`define FP_CLASS_W  10

// Flag positions in fflags
`define FP_FLAG_NV  4
`define FP_FLAG_NX  0

`define FP_QNAN     32'h7FC00000  // Canonical quiet NaN

// Opcodes
`define FP_OP_MIN       5'h05
`define FP_OP_MAX       5'h06
`define FP_OP_SGNJ      5'h0B
`define FP_OP_SGNJN     5'h0C
`define FP_OP_SGNJX     5'h0D
`define FP_OP_CVT_W     5'h0E
`define FP_OP_CVT_WU    5'h0F
`define FP_OP_CVT_S_W   5'h10
`define FP_OP_CVT_S_WU  5'h11
`define FP_OP_MV_X_W    5'h12
`define FP_OP_MV_W_X    5'h13
`define FP_OP_CLASS     5'h14
`define FP_OP_EQ        5'h15
`define FP_OP_LT        5'h16
`define FP_OP_LE        5'h17

`endif
